// ==== mips_macros.svh ====
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Datapath word width
`define WORD_W 32

// Unified memory size in words
`define MEM_DEPTH 256
`define MEM_AW 8

// Major opcodes
`define OP_RTYPE 6'd0
`define OP_J 6'd2
`define OP_BEQ 6'd4
`define OP_BNE 6'd5
`define OP_ADDI 6'd8
`define OP_SLTI 6'h0A
`define OP_ANDI 6'h0C
`define OP_ORI 6'h0D
`define OP_XORI 6'h0E
`define OP_LUI 6'h0F
`define OP_LW 6'd35
`define OP_SW 6'd43

// R-type funct codes
`define FN_SLL 6'd0
`define FN_SRL 6'd2
`define FN_SRA 6'd3
`define FN_ADD 6'd32
`define FN_SUB 6'd34
`define FN_AND 6'd36
`define FN_OR 6'd37
`define FN_XOR 6'd38
`define FN_NOR 6'd39
`define FN_SLT 6'd42

`endif

// ==== mips_pkg.sv ====
`include "mips_macros.svh"

package mips_pkg;

	typedef logic [`WORD_W-1:0] word_t;

	// Register format
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFmt_t;

	// Immediate format
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} iFmt_t;

	// Jump format
	typedef struct packed {
		logic [5:0] opcode;
		logic [25:0] target;
	} jFmt_t;

	// Same instruction word, three views
	typedef union packed {
		rFmt_t rFmt;
		iFmt_t iFmt;
		jFmt_t jFmt;
	} instr_t;

	typedef enum logic [1:0] {
		ALUOP_ADD = 2'b00,
		ALUOP_SUB = 2'b01,
		ALUOP_RFUNCT = 2'b10,
		ALUOP_IMM = 2'b11
	} aluOp_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} aluCtrl_t;

	// Sequencer states
	typedef enum logic [3:0] {
		FETCH = 4'd0,
		DECODE = 4'd1,
		MEM_ADR = 4'd2,
		MEM_READ = 4'd3,
		MEM_WRITEBACK = 4'd4,
		MEM_WRITE = 4'd5,
		EXECUTE = 4'd6,
		ALU_WRITEBACK = 4'd7,
		BRANCH = 4'd8,
		ITYPE_EXECUTE = 4'd9,
		ITYPE_WRITEBACK = 4'd10,
		JUMP = 4'd11,
		PRE_FETCH = 4'd12
	} cuState_t;

	// Datapath control bundle
	typedef struct packed {
		logic memToReg;
		logic iOrD;
		logic regDst;
		logic [1:0] pcSrc;
		logic [1:0] aluSrcA;
		logic [1:0] aluSrcB;
		logic [1:0] branch;
		logic irWrite;
		logic memWrite;
		logic pcWrite;
		logic regWrite;
		logic extOp;
		aluCtrl_t aluControl;
	} ctrl_t;

endpackage

// ==== alu_decoder.sv ====
`timescale 1ns/1ns
`include "mips_macros.svh"

module alu_decoder import mips_pkg::*; (
	input aluOp_t aluOp,
	input logic [5:0] funct,
	input logic [5:0] opcode,
	output aluCtrl_t aluControl
);

	always_comb begin
		aluControl = ALU_ADD;
		case (aluOp)
			// Address and PC arithmetic
			ALUOP_ADD: aluControl = ALU_ADD;
			// Branch compare
			ALUOP_SUB: aluControl = ALU_SUB;
			ALUOP_RFUNCT: begin
				case (funct)
					`FN_ADD: aluControl = ALU_ADD;
					`FN_SUB: aluControl = ALU_SUB;
					`FN_AND: aluControl = ALU_AND;
					`FN_OR: aluControl = ALU_OR;
					`FN_XOR: aluControl = ALU_XOR;
					`FN_NOR: aluControl = ALU_NOR;
					`FN_SLT: aluControl = ALU_SLT;
					`FN_SLL: aluControl = ALU_SLL;
					`FN_SRL: aluControl = ALU_SRL;
					`FN_SRA: aluControl = ALU_SRA;
					default: aluControl = ALU_ADD;
				endcase
			end
			ALUOP_IMM: begin
				// I-type ops picked by opcode
				case (opcode)
					`OP_ADDI: aluControl = ALU_ADD;
					`OP_SLTI: aluControl = ALU_SLT;
					`OP_ANDI: aluControl = ALU_AND;
					`OP_ORI: aluControl = ALU_OR;
					`OP_XORI: aluControl = ALU_XOR;
					`OP_LUI: aluControl = ALU_LUI;
					default: aluControl = ALU_ADD;
				endcase
			end
			default: aluControl = ALU_ADD;
		endcase
	end

endmodule

// ==== control_unit.sv ====
`timescale 1ns/1ns
`include "mips_macros.svh"

module control_unit import mips_pkg::*; (
	input logic cclk,
	input logic rstb,
	input instr_t instr,
	output ctrl_t ctrl
);

	cuState_t state;
	cuState_t stateNext;
	aluOp_t aluOp;
	aluCtrl_t aluControl;
	logic [5:0] opcode;
	logic [5:0] funct;
	logic isShift;

	assign opcode = instr.rFmt.opcode;
	assign funct = instr.rFmt.funct;
	// Shifts take their operand from B
	assign isShift = (funct == `FN_SLL) || (funct == `FN_SRL) || (funct == `FN_SRA);

	alu_decoder aluDecoder (
		.aluOp(aluOp),
		.funct(funct),
		.opcode(opcode),
		.aluControl(aluControl)
	);

	// State register
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			state <= PRE_FETCH;
		end else begin
			state <= stateNext;
		end
	end

	// Next state
	always_comb begin
		stateNext = state;
		case (state)
			PRE_FETCH: stateNext = FETCH;
			FETCH: stateNext = DECODE;
			DECODE: begin
				// Unknown opcode parks the sequencer here
				case (opcode)
					`OP_LW, `OP_SW: stateNext = MEM_ADR;
					`OP_RTYPE: stateNext = EXECUTE;
					`OP_BEQ, `OP_BNE: stateNext = BRANCH;
					`OP_ADDI, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
						stateNext = ITYPE_EXECUTE;
					end
					`OP_J: stateNext = JUMP;
					default: stateNext = DECODE;
				endcase
			end
			MEM_ADR: begin
				case (opcode)
					`OP_LW: stateNext = MEM_READ;
					`OP_SW: stateNext = MEM_WRITE;
					default: stateNext = MEM_ADR;
				endcase
			end
			MEM_READ: stateNext = MEM_WRITEBACK;
			EXECUTE: stateNext = ALU_WRITEBACK;
			ITYPE_EXECUTE: stateNext = ITYPE_WRITEBACK;
			// Last state of every instruction
			MEM_WRITEBACK, MEM_WRITE, ALU_WRITEBACK, BRANCH, ITYPE_WRITEBACK, JUMP: begin
				stateNext = PRE_FETCH;
			end
			default: stateNext = PRE_FETCH;
		endcase
	end

	// Control outputs per state
	always_comb begin
		ctrl = '0;
		aluOp = ALUOP_ADD;
		// Zero extension only for the logic immediates
		ctrl.extOp = !((opcode == `OP_ANDI) || (opcode == `OP_ORI) || (opcode == `OP_XORI));
		case (state)
			// Memory read at PC, nothing written
			PRE_FETCH: ctrl.iOrD = 1'b0;
			FETCH: begin
				// IR load and PC+4 in one edge
				ctrl.aluSrcA = 2'd0;
				ctrl.aluSrcB = 2'd1;
				ctrl.pcSrc = 2'd0;
				ctrl.irWrite = 1'b1;
				ctrl.pcWrite = 1'b1;
			end
			DECODE: begin
				// Branch target into ALUOut
				ctrl.aluSrcA = 2'd0;
				ctrl.aluSrcB = 2'd3;
			end
			MEM_ADR: begin
				ctrl.aluSrcA = 2'd1;
				ctrl.aluSrcB = 2'd2;
			end
			MEM_READ: ctrl.iOrD = 1'b1;
			MEM_WRITEBACK: begin
				ctrl.memToReg = 1'b1;
				ctrl.regDst = 1'b0;
				ctrl.regWrite = 1'b1;
			end
			MEM_WRITE: begin
				ctrl.iOrD = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			EXECUTE: begin
				ctrl.aluSrcA = isShift ? 2'd2 : 2'd1;
				ctrl.aluSrcB = 2'd0;
				aluOp = ALUOP_RFUNCT;
			end
			ALU_WRITEBACK: begin
				ctrl.regDst = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			BRANCH: begin
				// Compare A and B, PC from ALUOut
				ctrl.pcSrc = 2'd1;
				ctrl.aluSrcA = 2'd1;
				ctrl.aluSrcB = 2'd0;
				ctrl.branch = {opcode == `OP_BNE, opcode == `OP_BEQ};
				aluOp = ALUOP_SUB;
			end
			ITYPE_EXECUTE: begin
				ctrl.aluSrcA = 2'd1;
				ctrl.aluSrcB = 2'd2;
				aluOp = ALUOP_IMM;
			end
			ITYPE_WRITEBACK: begin
				ctrl.regDst = 1'b0;
				ctrl.regWrite = 1'b1;
			end
			JUMP: begin
				ctrl.pcSrc = 2'd2;
				ctrl.pcWrite = 1'b1;
			end
			default: ctrl.iOrD = 1'b0;
		endcase
		ctrl.aluControl = aluControl;
	end

	// Memory store and register write belong to different states
	assert property (@(posedge cclk) disable iff (!rstb)
		!(ctrl.memWrite && ctrl.regWrite));

	// Only supported opcodes get decoded
	assert property (@(posedge cclk) disable iff (!rstb)
		state == DECODE |=> state != DECODE);

endmodule

// ==== alu.sv ====
`timescale 1ns/1ns

module alu import mips_pkg::*; (
	input word_t a,
	input word_t b,
	input logic [4:0] shamt,
	input aluCtrl_t op,
	output word_t y,
	output logic zero
);

	always_comb begin
		case (op)
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_AND: y = a & b;
			ALU_OR: y = a | b;
			ALU_XOR: y = a ^ b;
			ALU_NOR: y = ~(a | b);
			// Signed compare
			ALU_SLT: y = {31'b0, $signed(a) < $signed(b)};
			// Shifts act on b by shamt
			ALU_SLL: y = b << shamt;
			ALU_SRL: y = b >> shamt;
			ALU_SRA: y = $signed(b) >>> shamt;
			// Immediate to upper half
			ALU_LUI: y = {b[15:0], 16'b0};
			default: y = a + b;
		endcase
	end

	// Equal operands after subtract
	assign zero = (y == '0);

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ns

module reg_file import mips_pkg::*; (
	input logic cclk,
	input logic we,
	input logic [4:0] ra1,
	input logic [4:0] ra2,
	input logic [4:0] wa,
	input word_t wd,
	output word_t rd1,
	output word_t rd2
);

	word_t regs [32];

	// Writes to r0 are dropped
	always_ff @(posedge cclk) begin
		if (we && (wa != 5'd0)) begin
			regs[wa] <= wd;
		end
	end

	// Reads are combinational, r0 hardwired
	assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

// ==== datapath.sv ====
`timescale 1ns/1ns
`include "mips_macros.svh"

module datapath import mips_pkg::*; (
	input logic cclk,
	input logic rstb,
	input ctrl_t ctrl,
	input word_t memRData,
	output instr_t instr,
	output logic [`MEM_AW-1:0] memAddr,
	output word_t memWData,
	output logic memWrite
);

	word_t pc;
	word_t pcNext;
	instr_t ir;
	word_t regA;
	word_t regB;
	word_t aluOut;
	word_t rd1;
	word_t rd2;
	word_t srcA;
	word_t srcB;
	word_t aluY;
	word_t extImm;
	word_t wd;
	logic [4:0] wa;
	logic aluZero;
	logic pcEn;

	// Sign or zero extension of the immediate
	assign extImm = ctrl.extOp ? {{16{ir.iFmt.imm[15]}}, ir.iFmt.imm} : {16'b0, ir.iFmt.imm};

	// Operand A: PC, A reg, or B reg for shifts
	always_comb begin
		case (ctrl.aluSrcA)
			2'd1: srcA = regA;
			2'd2: srcA = regB;
			default: srcA = pc;
		endcase
	end

	// Operand B
	always_comb begin
		case (ctrl.aluSrcB)
			2'd0: srcB = regB;
			2'd1: srcB = 32'd4;
			2'd2: srcB = extImm;
			default: srcB = extImm << 2;
		endcase
	end

	alu aluInst (
		.a(srcA),
		.b(srcB),
		.shamt(ir.rFmt.shamt),
		.op(ctrl.aluControl),
		.y(aluY),
		.zero(aluZero)
	);

	// Write back target and data; loaded word comes straight from the memory register
	assign wa = ctrl.regDst ? ir.rFmt.rd : ir.rFmt.rt;
	assign wd = ctrl.memToReg ? memRData : aluOut;

	reg_file regFile (
		.cclk(cclk),
		.we(ctrl.regWrite),
		.ra1(ir.rFmt.rs),
		.ra2(ir.rFmt.rt),
		.wa(wa),
		.wd(wd),
		.rd1(rd1),
		.rd2(rd2)
	);

	// Next PC: incremented, branch target, or jump target
	always_comb begin
		case (ctrl.pcSrc)
			2'd1: pcNext = aluOut;
			2'd2: pcNext = {pc[31:28], ir.jFmt.target, 2'b00};
			default: pcNext = aluY;
		endcase
	end

	// beq on zero, bne on nonzero
	assign pcEn = ctrl.pcWrite | (ctrl.branch[0] & aluZero) | (ctrl.branch[1] & ~aluZero);

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			pc <= '0;
		end else if (pcEn) begin
			pc <= pcNext;
		end
	end

	// IR on fetch, the rest every cycle
	always_ff @(posedge cclk) begin
		if (ctrl.irWrite) begin
			ir <= memRData;
		end
		regA <= rd1;
		regB <= rd2;
		aluOut <= aluY;
	end

	assign instr = ir;
	// Byte address to word address
	assign memAddr = ctrl.iOrD ? aluOut[`MEM_AW+1:2] : pc[`MEM_AW+1:2];
	assign memWData = regB;
	assign memWrite = ctrl.memWrite;

	// Offsets are scaled by four, so PC never leaves a word boundary
	assert property (@(posedge cclk) disable iff (!rstb) pc[1:0] == 2'b00);

endmodule

// ==== unified_memory.sv ====
`timescale 1ns/1ns
`include "mips_macros.svh"

module unified_memory import mips_pkg::*; (
	input logic cclk,
	input logic [`MEM_AW-1:0] addr,
	input word_t wData,
	input logic we,
	input logic loadEn,
	input logic [`MEM_AW-1:0] loadAddr,
	input word_t loadData,
	output word_t rData
);

	word_t mem [`MEM_DEPTH];

	// Load port wins over the core
	always_ff @(posedge cclk) begin
		if (loadEn) begin
			mem[loadAddr] <= loadData;
		end else if (we) begin
			mem[addr] <= wData;
		end
	end

	// Registered read, one cycle after the address
	always_ff @(posedge cclk) begin
		rData <= mem[addr];
	end

	// Program loading only happens with the core held in reset
	assert property (@(posedge cclk) !(we && loadEn));

endmodule

// ==== mips_top.sv ====
`timescale 1ns/1ns
`include "mips_macros.svh"

module mips_top import mips_pkg::*; (
	input logic cclk,
	input logic rstb,
	input logic loadEn,
	input logic [`MEM_AW-1:0] loadAddr,
	input word_t loadData,
	output logic storeEn,
	output logic [`MEM_AW-1:0] storeAddr,
	output word_t storeData
);

	ctrl_t ctrl;
	instr_t instr;
	word_t memRData;
	word_t memWData;
	logic [`MEM_AW-1:0] memAddr;
	logic memWrite;

	control_unit controlUnit (
		.cclk(cclk),
		.rstb(rstb),
		.instr(instr),
		.ctrl(ctrl)
	);

	datapath dp (
		.cclk(cclk),
		.rstb(rstb),
		.ctrl(ctrl),
		.memRData(memRData),
		.instr(instr),
		.memAddr(memAddr),
		.memWData(memWData),
		.memWrite(memWrite)
	);

	unified_memory mem (
		.cclk(cclk),
		.addr(memAddr),
		.wData(memWData),
		.we(memWrite),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.rData(memRData)
	);

	// Every core store is visible here
	assign storeEn = memWrite;
	assign storeAddr = memAddr;
	assign storeData = memWData;

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
	output logic cclk,
	output logic porRstb
);

	// 20 ns period
	initial begin
		cclk = 1'b0;
		forever #10 cclk = ~cclk;
	end

	// Power-on reset for 5 cycles, released just after an edge
	initial begin
		porRstb = 1'b0;
		repeat (5) @(posedge cclk);
		#2;
		porRstb = 1'b1;
	end

endmodule

// ==== tb_mips.sv ====
`timescale 1ns/1ns
`include "mips_macros.svh"

module tb_mips import mips_pkg::*; ();

	// Cycles allowed between two expected stores
	localparam int storeTimeout = 400;

	logic cclk;
	logic porRstb;
	logic testRstb;
	logic rstb;
	logic loadEn;
	logic [`MEM_AW-1:0] loadAddr;
	word_t loadData;
	logic storeEn;
	logic [`MEM_AW-1:0] storeAddr;
	word_t storeData;

	logic [15:0] lfsrState;
	instr_t prog [$];
	int errorCount;
	int checkCount;
	int testCount;
	int failedTests;
	int testErrStart;

	// Core held by power-on reset or by a test
	assign rstb = porRstb & testRstb;

	tb_clock clkGen (
		.cclk(cclk),
		.porRstb(porRstb)
	);

	mips_top dut_i (
		.cclk(cclk),
		.rstb(rstb),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.storeEn(storeEn),
		.storeAddr(storeAddr),
		.storeData(storeData)
	);

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsrBit();
		logic lsb;
		lsb = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (lsb) begin
			lfsrState = lfsrState ^ 16'hB400;
		end
		return lsb;
	endfunction

	// One LFSR step per bit taken
	function automatic word_t randBits(input int n);
		word_t r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			r = {r[30:0], lfsrBit()};
		end
		return r;
	endfunction

	function automatic word_t sext16(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	// Instruction encoders
	function automatic instr_t rInstr(input logic [5:0] funct, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
		instr_t w;
		w.rFmt.opcode = `OP_RTYPE;
		w.rFmt.rs = rs;
		w.rFmt.rt = rt;
		w.rFmt.rd = rd;
		w.rFmt.shamt = shamt;
		w.rFmt.funct = funct;
		return w;
	endfunction

	function automatic instr_t iInstr(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		instr_t w;
		w.iFmt.opcode = op;
		w.iFmt.rs = rs;
		w.iFmt.rt = rt;
		w.iFmt.imm = imm;
		return w;
	endfunction

	// Target field is the word index when the upper PC bits are zero
	function automatic instr_t jInstr(input int wordIdx);
		instr_t w;
		w.jFmt.opcode = `OP_J;
		w.jFmt.target = 26'(wordIdx);
		return w;
	endfunction

	// Absolute word address through r0
	function automatic instr_t storeInstr(input logic [4:0] rt, input logic [`MEM_AW-1:0] addr);
		return iInstr(`OP_SW, 5'd0, rt, 16'({addr, 2'b00}));
	endfunction

	function automatic instr_t loadInstr(input logic [4:0] rt, input logic [`MEM_AW-1:0] addr);
		return iInstr(`OP_LW, 5'd0, rt, 16'({addr, 2'b00}));
	endfunction

	function automatic void emit(input instr_t i);
		prog.push_back(i);
	endfunction

	// J to itself closes every program
	function automatic void emitHalt();
		emit(jInstr(prog.size()));
	endfunction

	// ISA result of the R-type logic and arithmetic ops
	function automatic word_t refR(input logic [5:0] fn, input word_t a, input word_t b);
		case (fn)
			`FN_ADD: return a + b;
			`FN_SUB: return a - b;
			`FN_AND: return a & b;
			`FN_OR: return a | b;
			`FN_XOR: return a ^ b;
			`FN_NOR: return ~(a | b);
			`FN_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: return 'x;
		endcase
	endfunction

	// Inputs change 2 ns after the edge
	task automatic stepCycle();
		@(posedge cclk);
		#2;
	endtask

	task automatic loadWord(input logic [`MEM_AW-1:0] addr, input word_t data);
		loadEn = 1'b1;
		loadAddr = addr;
		loadData = data;
		stepCycle();
		loadEn = 1'b0;
	endtask

	task automatic loadProgram();
		foreach (prog[i]) begin
			loadWord(i[`MEM_AW-1:0], prog[i]);
		end
	endtask

	task automatic startTest();
		testErrStart = errorCount;
		prog.delete();
		stepCycle();
		testRstb = 1'b0;
		// Let the FSM settle in PRE_FETCH before loading
		stepCycle();
		stepCycle();
	endtask

	task automatic releaseReset();
		stepCycle();
		stepCycle();
		testRstb = 1'b1;
	endtask

	task automatic finishTest(input string name);
		testCount++;
		if (errorCount == testErrStart) begin
			$display("%s: passed", name);
		end else begin
			failedTests++;
			$display("%s: failed with %0d errors", name, errorCount - testErrStart);
		end
	endtask

	task automatic checkWord(input word_t got, input word_t exp, input string what);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("FAIL at %0t: %s data %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkAddr(input logic [`MEM_AW-1:0] got, input logic [`MEM_AW-1:0] exp,
		input string what);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("FAIL at %0t: %s address %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// Store strobe sampled mid-cycle
	task automatic waitStore(output logic [`MEM_AW-1:0] addr, output word_t data, output bit seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		addr = '0;
		data = '0;
		while (!seen && cycles < storeTimeout) begin
			@(negedge cclk);
			if (storeEn === 1'b1) begin
				seen = 1'b1;
				addr = storeAddr;
				data = storeData;
			end
			cycles++;
		end
	endtask

	task automatic expectStore(input logic [`MEM_AW-1:0] exAddr, input word_t exData,
		input string what);
		logic [`MEM_AW-1:0] addr;
		word_t data;
		bit seen;
		waitStore(addr, data, seen);
		if (!seen) begin
			errorCount++;
			$display("Timed out at %0t waiting for the %s store", $time, what);
		end else begin
			checkAddr(addr, exAddr, what);
			checkWord(data, exData, what);
		end
	endtask

	// ADD through SLT on two sign-extended immediates
	task automatic aluOpsTest();
		logic [15:0] immA;
		logic [15:0] immB;
		word_t a;
		word_t b;
		logic [5:0] fns [7];
		startTest();
		fns = '{`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_XOR, `FN_NOR, `FN_SLT};
		immA = 16'(randBits(16));
		immB = 16'(randBits(16));
		a = sext16(immA);
		b = sext16(immB);
		emit(iInstr(`OP_ADDI, 5'd0, 5'd1, immA));
		emit(iInstr(`OP_ADDI, 5'd0, 5'd2, immB));
		for (int k = 0; k < 7; k++) begin
			emit(rInstr(fns[k], 5'd1, 5'd2, 5'd3, 5'd0));
			emit(storeInstr(5'd3, 8'(128 + k)));
		end
		// Reversed SLT for the other outcome
		emit(rInstr(`FN_SLT, 5'd2, 5'd1, 5'd3, 5'd0));
		emit(storeInstr(5'd3, 8'd135));
		emitHalt();
		loadProgram();
		releaseReset();
		for (int k = 0; k < 7; k++) begin
			expectStore(8'(128 + k), refR(fns[k], a, b), $sformatf("alu op %0d", k));
		end
		expectStore(8'd135, refR(`FN_SLT, b, a), "reversed slt");
		finishTest("alu ops");
	endtask

	task automatic shiftTest();
		logic [15:0] hi;
		logic [15:0] lo;
		logic [4:0] s1;
		logic [4:0] s2;
		logic [4:0] s3;
		word_t v;
		startTest();
		// Negative value so SRA shows sign fill
		hi = 16'h8000 | 16'(randBits(16));
		lo = 16'(randBits(16));
		s1 = 5'(randBits(5));
		s2 = 5'(randBits(5));
		s3 = 5'(randBits(5)) | 5'd1;
		v = {hi, lo};
		emit(iInstr(`OP_LUI, 5'd0, 5'd1, hi));
		emit(iInstr(`OP_ORI, 5'd1, 5'd1, lo));
		emit(rInstr(`FN_SLL, 5'd0, 5'd1, 5'd2, s1));
		emit(storeInstr(5'd2, 8'd144));
		emit(rInstr(`FN_SRL, 5'd0, 5'd1, 5'd3, s2));
		emit(storeInstr(5'd3, 8'd145));
		emit(rInstr(`FN_SRA, 5'd0, 5'd1, 5'd4, s3));
		emit(storeInstr(5'd4, 8'd146));
		// Positive operand for SRA
		emit(rInstr(`FN_SRL, 5'd0, 5'd1, 5'd5, 5'd1));
		emit(rInstr(`FN_SRA, 5'd0, 5'd5, 5'd6, s3));
		emit(storeInstr(5'd6, 8'd147));
		emitHalt();
		loadProgram();
		releaseReset();
		expectStore(8'd144, v << s1, "sll");
		expectStore(8'd145, v >> s2, "srl");
		expectStore(8'd146, $signed(v) >>> s3, "sra negative");
		expectStore(8'd147, (v >> 1) >> s3, "sra positive");
		finishTest("shifts");
	endtask

	task automatic immTest();
		logic [15:0] hiA;
		logic [15:0] loA;
		logic [15:0] immL;
		logic [15:0] immS;
		logic [15:0] immU;
		word_t a;
		word_t zImm;
		startTest();
		hiA = 16'(randBits(16));
		loA = 16'(randBits(16));
		// Top bit set, so zero and sign extension differ
		immL = 16'h8000 | 16'(randBits(16));
		immS = 16'(randBits(16));
		immU = 16'(randBits(16));
		a = {hiA, loA};
		zImm = {16'h0000, immL};
		emit(iInstr(`OP_LUI, 5'd0, 5'd1, hiA));
		emit(iInstr(`OP_ORI, 5'd1, 5'd1, loA));
		emit(iInstr(`OP_ANDI, 5'd1, 5'd2, immL));
		emit(storeInstr(5'd2, 8'd176));
		emit(iInstr(`OP_ORI, 5'd1, 5'd3, immL));
		emit(storeInstr(5'd3, 8'd177));
		emit(iInstr(`OP_XORI, 5'd1, 5'd4, immL));
		emit(storeInstr(5'd4, 8'd178));
		emit(iInstr(`OP_SLTI, 5'd1, 5'd5, immS));
		emit(storeInstr(5'd5, 8'd179));
		// -3 against -2 and -4
		emit(iInstr(`OP_ADDI, 5'd0, 5'd6, 16'hFFFD));
		emit(iInstr(`OP_SLTI, 5'd6, 5'd7, 16'hFFFE));
		emit(storeInstr(5'd7, 8'd180));
		emit(iInstr(`OP_SLTI, 5'd6, 5'd8, 16'hFFFC));
		emit(storeInstr(5'd8, 8'd181));
		emit(iInstr(`OP_LUI, 5'd0, 5'd9, immU));
		emit(storeInstr(5'd9, 8'd182));
		emitHalt();
		loadProgram();
		releaseReset();
		expectStore(8'd176, a & zImm, "andi");
		expectStore(8'd177, a | zImm, "ori");
		expectStore(8'd178, a ^ zImm, "xori");
		expectStore(8'd179, ($signed(a) < $signed(sext16(immS))) ? 32'd1 : 32'd0, "slti");
		expectStore(8'd180, 32'd1, "slti taken");
		expectStore(8'd181, 32'd0, "slti not taken");
		expectStore(8'd182, {immU, 16'h0000}, "lui");
		finishTest("i-type");
	endtask

	task automatic memRoundTrip();
		logic [15:0] hi;
		logic [15:0] lo;
		word_t v;
		word_t pre;
		startTest();
		hi = 16'(randBits(16));
		lo = 16'(randBits(16));
		v = {hi, lo};
		pre = randBits(32);
		emit(iInstr(`OP_LUI, 5'd0, 5'd1, hi));
		emit(iInstr(`OP_ORI, 5'd1, 5'd1, lo));
		emit(storeInstr(5'd1, 8'd192));
		emit(loadInstr(5'd2, 8'd192));
		emit(storeInstr(5'd2, 8'd193));
		emit(loadInstr(5'd3, 8'd200));
		emit(storeInstr(5'd3, 8'd194));
		// Base register plus offset
		emit(iInstr(`OP_ADDI, 5'd0, 5'd4, 16'd784));
		emit(iInstr(`OP_SW, 5'd4, 5'd1, 16'd4));
		emitHalt();
		loadProgram();
		loadWord(8'd200, pre);
		releaseReset();
		expectStore(8'd192, v, "first sw");
		expectStore(8'd193, v, "sw of loaded word");
		expectStore(8'd194, pre, "sw of preloaded word");
		expectStore(8'd197, v, "sw with base");
		finishTest("memory round trip");
	endtask

	// Addresses 210, 213 and 215 sit on skipped paths
	task automatic controlFlow();
		logic [15:0] mark;
		word_t markW;
		startTest();
		mark = 16'(randBits(16));
		markW = sext16(mark);
		emit(iInstr(`OP_ADDI, 5'd0, 5'd1, 16'd5));
		emit(iInstr(`OP_ADDI, 5'd0, 5'd2, 16'd5));
		emit(iInstr(`OP_ADDI, 5'd0, 5'd3, 16'd7));
		emit(iInstr(`OP_ADDI, 5'd0, 5'd4, mark));
		// BEQ taken
		emit(iInstr(`OP_BEQ, 5'd1, 5'd2, 16'd1));
		emit(storeInstr(5'd4, 8'd210));
		emit(storeInstr(5'd4, 8'd211));
		// BEQ not taken
		emit(iInstr(`OP_BEQ, 5'd1, 5'd3, 16'd1));
		emit(storeInstr(5'd4, 8'd212));
		// BNE taken
		emit(iInstr(`OP_BNE, 5'd1, 5'd3, 16'd1));
		emit(storeInstr(5'd4, 8'd213));
		// BNE not taken
		emit(iInstr(`OP_BNE, 5'd1, 5'd2, 16'd1));
		emit(storeInstr(5'd4, 8'd214));
		// J over one store
		emit(jInstr(prog.size() + 2));
		emit(storeInstr(5'd4, 8'd215));
		emit(storeInstr(5'd4, 8'd216));
		emitHalt();
		loadProgram();
		releaseReset();
		expectStore(8'd211, markW, "after beq taken");
		expectStore(8'd212, markW, "after beq not taken");
		expectStore(8'd214, markW, "after bne not taken");
		expectStore(8'd216, markW, "after j");
		finishTest("control flow");
	endtask

	task automatic zeroRegAndReset();
		logic [15:0] imm;
		word_t v;
		startTest();
		imm = 16'(randBits(16));
		v = sext16(imm);
		emit(iInstr(`OP_ADDI, 5'd0, 5'd1, imm));
		emit(storeInstr(5'd1, 8'd220));
		// Both writes to r0 must be lost
		emit(iInstr(`OP_ADDI, 5'd0, 5'd0, 16'h1234));
		emit(rInstr(`FN_ADD, 5'd1, 5'd1, 5'd0, 5'd0));
		emit(storeInstr(5'd0, 8'd221));
		emitHalt();
		loadProgram();
		releaseReset();
		expectStore(8'd220, v, "first store");
		// Reset before the r0 store
		stepCycle();
		testRstb = 1'b0;
		repeat (3) stepCycle();
		releaseReset();
		expectStore(8'd220, v, "first store after reset");
		expectStore(8'd221, 32'd0, "r0 store");
		finishTest("r0 and reset");
	endtask

	initial begin
		int waitCycles;
		testRstb = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		lfsrState = 16'd62;
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		failedTests = 0;
		testErrStart = 0;
		waitCycles = 0;
		while (porRstb !== 1'b1 && waitCycles < 100) begin
			@(posedge cclk);
			waitCycles++;
		end
		if (porRstb !== 1'b1) begin
			errorCount++;
			$display("Power-on reset was never released");
		end
		aluOpsTest();
		shiftTest();
		immTest();
		memRoundTrip();
		controlFlow();
		zeroRegAndReset();
		$display("Tests %0d, failed %0d, checks %0d, errors %0d",
			testCount, failedTests, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+.
mips_pkg.sv
alu_decoder.sv
control_unit.sv
alu.sv
reg_file.sv
datapath.sv
unified_memory.sv
mips_top.sv
tb_clock.sv
tb_mips.sv
